/* common/lbus_pkg.sv */
package lbus_pkg;

    localparam int LBUS_ADDR_W = 10;
    localparam int LBUS_DATA_W = 8;

    typedef logic [LBUS_ADDR_W-1:0] lbus_addr_t;
    typedef logic [LBUS_DATA_W-1:0] lbus_data_t;

    // identity and scratch
    localparam lbus_addr_t ADDR_DATA_WIDTH        = 10'h000;
    localparam lbus_addr_t ADDR_CPLD_TEST         = 10'h001;  // inverting scratch
    localparam lbus_addr_t ADDR_LOGIC_VERSION     = 10'h002;
    localparam lbus_addr_t ADDR_COMPILE_MONTH     = 10'h003;
    localparam lbus_addr_t ADDR_COMPILE_DATE      = 10'h004;
    localparam lbus_addr_t ADDR_PCB_VERSION       = 10'h005;
    localparam lbus_addr_t ADDR_BOARD_MAN_VERSION = 10'h006;
    localparam lbus_addr_t ADDR_BOARD_CONFIG      = 10'h007;
    localparam lbus_addr_t ADDR_TEST_MODE         = 10'h00d;

    // interrupt unit
    localparam lbus_addr_t ADDR_INT_SOURCE        = 10'h027;  // read only
    localparam lbus_addr_t ADDR_INT_MASK          = 10'h028;

    localparam lbus_addr_t ADDR_DEBUG_LED         = 10'h02f;

    // sfp cage bank
    localparam lbus_addr_t ADDR_TXDIS             = 10'h040;
    localparam lbus_addr_t ADDR_LED_LINK          = 10'h041;
    localparam lbus_addr_t ADDR_LED_ACT           = 10'h042;
    localparam lbus_addr_t ADDR_SFP_ONLINE_STATUS = 10'h050;  // raw presence
    localparam lbus_addr_t ADDR_SFP_LOS_STATUS    = 10'h051;  // raw loss of signal
    localparam lbus_addr_t ADDR_SFP_ONLINE_INT    = 10'h052;  // read to clear
    localparam lbus_addr_t ADDR_SFP_LOS_INT       = 10'h053;  // read to clear

    // stages of the access synchroniser
    localparam int SYNC_DEPTH = 4;

endpackage

/* common/board_pkg.sv */
package board_pkg;

    localparam int SFP_PORTS = 8;

    typedef logic [SFP_PORTS-1:0] sfp_vec_t;  // one bit per cage

    localparam int INT_MASK_W = 3;

    // identity bytes reported to the host
    localparam logic [7:0] LOGIC_DATA_WIDTH    = 8'h00;
    localparam logic [7:0] LOGIC_VERSION       = 8'h09;
    localparam logic [7:0] LOGIC_COMPILE_MONTH = 8'hb7;  // year and month
    localparam logic [7:0] LOGIC_COMPILE_DATE  = 8'h06;
    localparam logic [7:0] PCB_BOARD_VERSION   = 8'h01;
    localparam logic [7:0] BOARD_MAN_VERSION   = 8'h01;
    localparam logic [7:0] BOARD_CONFIG        = 8'h00;

    // register reset values
    localparam logic [7:0] TEST_MODE_RST       = 8'h03;
    localparam logic [7:0] DEBUG_LED_RST       = 8'h01;
    localparam logic [7:0] CAGE_CTRL_RST       = 8'hff;  // txdis, link and act leds off

endpackage

/* common/reg_access_if.sv */
`timescale 1ns/10ps

interface reg_access_if;
    import lbus_pkg::*;

    logic       wr_stb;  // one cycle per bus write
    logic       rd_stb;  // one cycle per bus read
    lbus_addr_t addr;    // valid during either strobe
    lbus_data_t wdata;   // valid during wr_stb

    modport ctrl
    (
        output wr_stb,
        output rd_stb,
        output addr,
        output wdata
    );

    modport bank
    (
        input  wr_stb,
        input  rd_stb,
        input  addr,
        input  wdata
    );

endinterface

/* design/lbus_ctrl.sv */
`timescale 1ns/10ps

module lbus_ctrl
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  lbus_pkg::lbus_addr_t lbus_addr,
    input  lbus_pkg::lbus_data_t lbus_d_in,
    input  logic                 lbus_cs_n,
    input  logic                 lbus_rd_n,
    input  logic                 lbus_wr_n,
    input  lbus_pkg::lbus_data_t board_rdata,
    input  lbus_pkg::lbus_data_t sfp_rdata,
    input  lbus_pkg::lbus_data_t int_rdata,
    output lbus_pkg::lbus_data_t lbus_d_out,
    output logic                 lbus_d_oe,
    output logic                 lbus_rdy_n,
    reg_access_if.ctrl           acc
);
    import lbus_pkg::*;

    logic                  wr_n;      // write qualified by chip select
    logic                  rd_n;      // read qualified by chip select
    logic [SYNC_DEPTH-1:0] wr_sync;   // bit 0 is stage one
    logic [SYNC_DEPTH-1:0] rd_sync;
    logic                  wr_stb;
    logic                  rd_stb;
    lbus_addr_t            addr_q;    // one stage deep
    lbus_data_t            wdata_q1;
    lbus_data_t            wdata_q2;  // two stages deep
    lbus_data_t            rdata_q;

    assign wr_n = lbus_cs_n | lbus_wr_n;
    assign rd_n = lbus_cs_n | lbus_rd_n;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_sync <= '1;
            rd_sync <= '1;
        end
        else
        begin
            wr_sync <= {wr_sync[SYNC_DEPTH-2:0], wr_n};
            rd_sync <= {rd_sync[SYNC_DEPTH-2:0], rd_n};
        end
    end

    // falling edge seen between stage four and stage three
    assign wr_stb = wr_sync[SYNC_DEPTH-1] & ~wr_sync[SYNC_DEPTH-2];
    assign rd_stb = rd_sync[SYNC_DEPTH-1] & ~rd_sync[SYNC_DEPTH-2];

    // address and data settle long before the strobe
    always_ff @(posedge clk)
    begin
        addr_q   <= lbus_addr;
        wdata_q1 <= lbus_d_in;
        wdata_q2 <= wdata_q1;
    end

    assign acc.wr_stb = wr_stb;
    assign acc.rd_stb = rd_stb;
    assign acc.addr   = addr_q;
    assign acc.wdata  = wdata_q2;

    // banks return zero unless they own the address
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rdata_q <= '0;
        end
        else if (rd_stb)
        begin
            rdata_q <= board_rdata | sfp_rdata | int_rdata;
        end
    end

    assign lbus_d_out = rdata_q;
    assign lbus_d_oe  = ~rd_n;         // pad drives while the host reads
    assign lbus_rdy_n = rd_n & wr_n;   // ready during any access

endmodule

/* design/board_info_regs.sv */
`timescale 1ns/10ps

module board_info_regs
(
    input  logic                 clk,
    input  logic                 rst_n,
    reg_access_if.bank           acc,
    output lbus_pkg::lbus_data_t rdata,
    output lbus_pkg::lbus_data_t test_mode,
    output lbus_pkg::lbus_data_t debugging_led
);
    import lbus_pkg::*;
    import board_pkg::*;

    lbus_data_t scratch;  // holds the inverted write

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scratch       <= '0;
            test_mode     <= TEST_MODE_RST;
            debugging_led <= DEBUG_LED_RST;
        end
        else if (acc.wr_stb)
        begin
            case (acc.addr)
                ADDR_CPLD_TEST: scratch       <= ~acc.wdata;  // stuck data line check
                ADDR_TEST_MODE: test_mode     <= acc.wdata;
                ADDR_DEBUG_LED: debugging_led <= acc.wdata;
                default:        ;
            endcase
        end
    end

    always_comb
    begin
        case (acc.addr)
            ADDR_DATA_WIDTH:        rdata = LOGIC_DATA_WIDTH;
            ADDR_CPLD_TEST:         rdata = scratch;
            ADDR_LOGIC_VERSION:     rdata = LOGIC_VERSION;
            ADDR_COMPILE_MONTH:     rdata = LOGIC_COMPILE_MONTH;
            ADDR_COMPILE_DATE:      rdata = LOGIC_COMPILE_DATE;
            ADDR_PCB_VERSION:       rdata = PCB_BOARD_VERSION;
            ADDR_BOARD_MAN_VERSION: rdata = BOARD_MAN_VERSION;
            ADDR_BOARD_CONFIG:      rdata = BOARD_CONFIG;
            ADDR_TEST_MODE:         rdata = test_mode;
            ADDR_DEBUG_LED:         rdata = debugging_led;
            default:                rdata = '0;  // not ours
        endcase
    end

endmodule

/* design/sfp_regs.sv */
`timescale 1ns/10ps

module sfp_regs
(
    input  logic                 clk,
    input  logic                 rst_n,
    reg_access_if.bank           acc,
    input  board_pkg::sfp_vec_t  sfp_abs,
    input  board_pkg::sfp_vec_t  sfp_los,
    input  board_pkg::sfp_vec_t  sfp_abs_flag,     // active low
    input  board_pkg::sfp_vec_t  sfp_los_flag,     // active low
    output lbus_pkg::lbus_data_t rdata,
    output board_pkg::sfp_vec_t  txdis,
    output board_pkg::sfp_vec_t  led_link,
    output board_pkg::sfp_vec_t  led_act,
    output logic                 reading_abs_int,
    output logic                 reading_los_int
);
    import lbus_pkg::*;
    import board_pkg::*;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            txdis    <= CAGE_CTRL_RST;
            led_link <= CAGE_CTRL_RST;
            led_act  <= CAGE_CTRL_RST;
        end
        else if (acc.wr_stb)
        begin
            case (acc.addr)
                ADDR_TXDIS:    txdis    <= acc.wdata;
                ADDR_LED_LINK: led_link <= acc.wdata;
                ADDR_LED_ACT:  led_act  <= acc.wdata;
                default:       ;
            endcase
        end
    end

    // pulse rises on the edge that loads the read data
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            reading_abs_int <= 1'b0;
            reading_los_int <= 1'b0;
        end
        else
        begin
            reading_abs_int <= acc.rd_stb && (acc.addr == ADDR_SFP_ONLINE_INT);
            reading_los_int <= acc.rd_stb && (acc.addr == ADDR_SFP_LOS_INT);
        end
    end

    always_comb
    begin
        case (acc.addr)
            ADDR_TXDIS:             rdata = txdis;
            ADDR_LED_LINK:          rdata = led_link;
            ADDR_LED_ACT:           rdata = led_act;
            ADDR_SFP_ONLINE_STATUS: rdata = sfp_abs;
            ADDR_SFP_LOS_STATUS:    rdata = sfp_los;
            ADDR_SFP_ONLINE_INT:    rdata = ~sfp_abs_flag;  // host sees flags high
            ADDR_SFP_LOS_INT:       rdata = ~sfp_los_flag;
            default:                rdata = '0;
        endcase
    end

endmodule

/* design/int_ctrl.sv */
`timescale 1ns/10ps

module int_ctrl
(
    input  logic                         clk,
    input  logic                         rst_n,
    reg_access_if.bank                   acc,
    input  logic                         lm80_n,           // temperature sensor alert
    input  logic                         sfp_abs_int_bit,
    input  logic                         sfp_los_int_bit,
    output lbus_pkg::lbus_data_t         rdata,
    output logic [board_pkg::INT_MASK_W-1:0] int_mask,
    output logic                         int_n
);
    import lbus_pkg::*;
    import board_pkg::*;

    logic                  lm80_src;
    logic [INT_MASK_W-1:0] int_src;  // {lm80, los, abs}

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            int_mask <= '0;
        end
        else if (acc.wr_stb && (acc.addr == ADDR_INT_MASK))
        begin
            int_mask <= acc.wdata[INT_MASK_W-1:0];
        end
    end

    // only the sensor source is maskable
    assign lm80_src = ~(lm80_n | int_mask[2]);
    assign int_src  = {lm80_src, sfp_los_int_bit, sfp_abs_int_bit};
    assign int_n    = ~|int_src;

    always_comb
    begin
        case (acc.addr)
            ADDR_INT_SOURCE: rdata = {{(LBUS_DATA_W-INT_MASK_W){1'b0}}, int_src};
            ADDR_INT_MASK:   rdata = {{(LBUS_DATA_W-INT_MASK_W){1'b0}}, int_mask};
            default:         rdata = '0;
        endcase
    end

endmodule

/* design/lbus_regs_top.sv */
`timescale 1ns/10ps

module lbus_regs_top
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  lbus_pkg::lbus_addr_t             lbus_addr,
    input  lbus_pkg::lbus_data_t             lbus_d_in,
    input  logic                             lbus_cs_n,
    input  logic                             lbus_rd_n,
    input  logic                             lbus_wr_n,
    output lbus_pkg::lbus_data_t             lbus_d_out,
    output logic                             lbus_d_oe,
    output logic                             lbus_rdy_n,
    output lbus_pkg::lbus_data_t             test_mode,
    output lbus_pkg::lbus_data_t             debugging_led,
    input  board_pkg::sfp_vec_t              sfp_abs,
    input  board_pkg::sfp_vec_t              sfp_los,
    input  board_pkg::sfp_vec_t              sfp_abs_flag,
    input  board_pkg::sfp_vec_t              sfp_los_flag,
    output board_pkg::sfp_vec_t              txdis,
    output board_pkg::sfp_vec_t              led_link,
    output board_pkg::sfp_vec_t              led_act,
    output logic                             reading_abs_int,
    output logic                             reading_los_int,
    input  logic                             lm80_n,
    input  logic                             sfp_abs_int_bit,
    input  logic                             sfp_los_int_bit,
    output logic [board_pkg::INT_MASK_W-1:0] int_mask,
    output logic                             int_n
);
    import lbus_pkg::*;

    lbus_data_t board_rdata;
    lbus_data_t sfp_rdata;
    lbus_data_t int_rdata;

    reg_access_if acc ();

    lbus_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .lbus_addr   (lbus_addr),
        .lbus_d_in   (lbus_d_in),
        .lbus_cs_n   (lbus_cs_n),
        .lbus_rd_n   (lbus_rd_n),
        .lbus_wr_n   (lbus_wr_n),
        .board_rdata (board_rdata),
        .sfp_rdata   (sfp_rdata),
        .int_rdata   (int_rdata),
        .lbus_d_out  (lbus_d_out),
        .lbus_d_oe   (lbus_d_oe),
        .lbus_rdy_n  (lbus_rdy_n),
        .acc         (acc.ctrl)
    );

    board_info_regs u_board (
        .clk           (clk),
        .rst_n         (rst_n),
        .acc           (acc.bank),
        .rdata         (board_rdata),
        .test_mode     (test_mode),
        .debugging_led (debugging_led)
    );

    sfp_regs u_sfp (
        .clk             (clk),
        .rst_n           (rst_n),
        .acc             (acc.bank),
        .sfp_abs         (sfp_abs),
        .sfp_los         (sfp_los),
        .sfp_abs_flag    (sfp_abs_flag),
        .sfp_los_flag    (sfp_los_flag),
        .rdata           (sfp_rdata),
        .txdis           (txdis),
        .led_link        (led_link),
        .led_act         (led_act),
        .reading_abs_int (reading_abs_int),
        .reading_los_int (reading_los_int)
    );

    int_ctrl u_int (
        .clk             (clk),
        .rst_n           (rst_n),
        .acc             (acc.bank),
        .lm80_n          (lm80_n),
        .sfp_abs_int_bit (sfp_abs_int_bit),
        .sfp_los_int_bit (sfp_los_int_bit),
        .rdata           (int_rdata),
        .int_mask        (int_mask),
        .int_n           (int_n)
    );

endmodule

/* dv/lbus_regs_assert.sv */
`timescale 1ns/10ps

module lbus_regs_assert
(
    input logic clk,
    input logic rst_n,
    input logic wr_stb,
    input logic rd_stb,
    input logic lbus_d_oe,
    input logic lbus_rdy_n
);

    int fails = 0;  // read by the testbench at the end of the run

    // one access at a time
    strobe_excl: assert property (@(posedge clk) disable iff (!rst_n) !(wr_stb && rd_stb))
        else begin $error("wr_stb and rd_stb high together"); fails++; end

    wr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) wr_stb |=> !wr_stb)
        else begin $error("wr_stb longer than one cycle"); fails++; end

    rd_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) rd_stb |=> !rd_stb)
        else begin $error("rd_stb longer than one cycle"); fails++; end

    // a read drives the pads only while the bus sees ready
    oe_ready: assert property (@(posedge clk) disable iff (!rst_n) lbus_d_oe |-> !lbus_rdy_n)
        else begin $error("lbus_d_oe high while lbus_rdy_n high"); fails++; end

endmodule

bind lbus_ctrl lbus_regs_assert u_assert
(
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_stb     (wr_stb),
    .rd_stb     (rd_stb),
    .lbus_d_oe  (lbus_d_oe),
    .lbus_rdy_n (lbus_rdy_n)
);

/* dv/lbus_regs_tb.sv */
`timescale 1ns/10ps

module lbus_regs_tb;
    import lbus_pkg::*;
    import board_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int BUS_CYCLES = 15 + 12 + 36 + 12 + 18 + 8;  // reads and writes of tests 1 to 6
    localparam lbus_addr_t RW_ADDRS[6] = '{ADDR_TEST_MODE, ADDR_DEBUG_LED, ADDR_TXDIS,
                                           ADDR_LED_LINK, ADDR_LED_ACT, ADDR_INT_MASK};
    localparam lbus_addr_t FREE_ADDRS[4] = '{10'h008, 10'h02a, 10'h060, 10'h3ff};
    localparam lbus_addr_t SFP_RD_ADDRS[4] = '{ADDR_SFP_ONLINE_STATUS, ADDR_SFP_LOS_STATUS,
                                               ADDR_SFP_ONLINE_INT, ADDR_SFP_LOS_INT};

    logic                  clk;
    logic                  rst_n;
    lbus_addr_t            lbus_addr;
    lbus_data_t            lbus_d_in;
    logic                  lbus_cs_n;
    logic                  lbus_rd_n;
    logic                  lbus_wr_n;
    lbus_data_t            lbus_d_out;
    logic                  lbus_d_oe;
    logic                  lbus_rdy_n;
    lbus_data_t            test_mode;
    lbus_data_t            debugging_led;
    sfp_vec_t              sfp_abs;
    sfp_vec_t              sfp_los;
    sfp_vec_t              sfp_abs_flag;
    sfp_vec_t              sfp_los_flag;
    sfp_vec_t              txdis;
    sfp_vec_t              led_link;
    sfp_vec_t              led_act;
    logic                  reading_abs_int;
    logic                  reading_los_int;
    logic                  lm80_n;
    logic                  sfp_abs_int_bit;
    logic                  sfp_los_int_bit;
    logic [INT_MASK_W-1:0] int_mask;
    logic                  int_n;

    // model of the writable registers
    lbus_data_t            m_scratch = '0;
    lbus_data_t            m_test    = TEST_MODE_RST;
    lbus_data_t            m_dbg     = DEBUG_LED_RST;
    sfp_vec_t              m_txdis   = CAGE_CTRL_RST;
    sfp_vec_t              m_link    = CAGE_CTRL_RST;
    sfp_vec_t              m_act     = CAGE_CTRL_RST;
    logic [INT_MASK_W-1:0] m_mask    = '0;

    integer     seed = 32'h8b19acfa;
    int         errors = 0;
    int         checks = 0;
    int         err_mark = 0;
    int         tests_ok = 0;
    int         tests_bad = 0;
    lbus_addr_t rd_addr;
    lbus_data_t rd_data;
    logic       saw_abs;
    logic       saw_los;
    event       read_done;

    lbus_regs_top lbus_regs_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [2:0] exp_int_src(input logic lm80, input logic los_bit,
                                               input logic abs_bit, input logic mask2);
        return {~lm80 & ~mask2, los_bit, abs_bit};  // sensor source is the only maskable one
    endfunction

    function automatic lbus_data_t ref_read(input lbus_addr_t a, input lbus_data_t scr,
        input lbus_data_t tm, input lbus_data_t dbg, input sfp_vec_t txd, input sfp_vec_t lnk,
        input sfp_vec_t act, input logic [2:0] mask, input sfp_vec_t abs_v, input sfp_vec_t los_v,
        input sfp_vec_t absf, input sfp_vec_t losf, input logic [2:0] irq);
        case (a)
            ADDR_DATA_WIDTH:        return LOGIC_DATA_WIDTH;
            ADDR_CPLD_TEST:         return scr;
            ADDR_LOGIC_VERSION:     return LOGIC_VERSION;
            ADDR_COMPILE_MONTH:     return LOGIC_COMPILE_MONTH;
            ADDR_COMPILE_DATE:      return LOGIC_COMPILE_DATE;
            ADDR_PCB_VERSION:       return PCB_BOARD_VERSION;
            ADDR_BOARD_MAN_VERSION: return BOARD_MAN_VERSION;
            ADDR_BOARD_CONFIG:      return BOARD_CONFIG;
            ADDR_TEST_MODE:         return tm;
            ADDR_DEBUG_LED:         return dbg;
            ADDR_TXDIS:             return txd;
            ADDR_LED_LINK:          return lnk;
            ADDR_LED_ACT:           return act;
            ADDR_SFP_ONLINE_STATUS: return abs_v;
            ADDR_SFP_LOS_STATUS:    return los_v;
            ADDR_SFP_ONLINE_INT:    return ~absf;  // flags are active low on the board
            ADDR_SFP_LOS_INT:       return ~losf;
            ADDR_INT_MASK:          return {5'b0, mask};
            ADDR_INT_SOURCE:        return {5'b0, exp_int_src(irq[2], irq[1], irq[0], mask[2])};
            default:                return 8'h00;
        endcase
    endfunction

    task automatic check_data(input string name, input lbus_data_t exp, input lbus_data_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_vec(input string name, input sfp_vec_t exp, input sfp_vec_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic model_write(input lbus_addr_t a, input lbus_data_t d);
        case (a)
            ADDR_CPLD_TEST: m_scratch = ~d;
            ADDR_TEST_MODE: m_test    = d;
            ADDR_DEBUG_LED: m_dbg     = d;
            ADDR_TXDIS:     m_txdis   = d;
            ADDR_LED_LINK:  m_link    = d;
            ADDR_LED_ACT:   m_act     = d;
            ADDR_INT_MASK:  m_mask    = d[2:0];
            default:        ;
        endcase
    endtask

    task automatic bus_write(input lbus_addr_t a, input lbus_data_t d);
        @(posedge clk);
        #1;
        lbus_addr = a;
        lbus_d_in = d;
        lbus_cs_n = 1'b0;
        lbus_wr_n = 1'b0;
        repeat (8) @(posedge clk);
        check_bit("lbus_d_oe", 1'b0, lbus_d_oe);    // pads stay off during a write
        check_bit("lbus_rdy_n", 1'b0, lbus_rdy_n);
        #1;
        lbus_cs_n = 1'b1;
        lbus_wr_n = 1'b1;
        repeat (2) @(posedge clk);
        check_bit("lbus_rdy_n", 1'b1, lbus_rdy_n);  // bus idle again
        model_write(a, d);
    endtask

    task automatic bus_read(input lbus_addr_t a);
        @(posedge clk);
        #1;
        lbus_addr = a;
        lbus_cs_n = 1'b0;
        lbus_rd_n = 1'b0;
        saw_abs = 1'b0;
        saw_los = 1'b0;
        repeat (8)
        begin
            @(negedge clk);
            saw_abs = saw_abs | reading_abs_int;  // pulse is one cycle wide
            saw_los = saw_los | reading_los_int;
        end
        check_bit("lbus_d_oe", 1'b1, lbus_d_oe);
        check_bit("lbus_rdy_n", 1'b0, lbus_rdy_n);
        rd_addr = a;
        rd_data = lbus_d_out;
        -> read_done;
        @(posedge clk);
        #1;
        lbus_cs_n = 1'b1;
        lbus_rd_n = 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic check_outputs;
        @(negedge clk);
        check_data("test_mode", m_test, test_mode);
        check_data("debugging_led", m_dbg, debugging_led);
        check_vec("txdis", m_txdis, txdis);
        check_vec("led_link", m_link, led_link);
        check_vec("led_act", m_act, led_act);
        check_data("int_mask", {5'b0, m_mask}, {5'b0, int_mask});
    endtask

    task automatic drive_irq(input logic lm80, input logic los_bit, input logic abs_bit);
        @(posedge clk);
        #1;
        lm80_n          = lm80;
        sfp_los_int_bit = los_bit;
        sfp_abs_int_bit = abs_bit;
        @(negedge clk);
        check_bit("int_n", ~|exp_int_src(lm80, los_bit, abs_bit, m_mask[2]), int_n);
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark)
        begin
            tests_ok++;
            $display("%s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("%s: %0d mismatches", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // compares every bus read against the reference
    initial
    begin
        forever
        begin
            @(read_done);
            check_data($sformatf("lbus_d_out@%h", rd_addr),
                       ref_read(rd_addr, m_scratch, m_test, m_dbg, m_txdis, m_link, m_act,
                                m_mask, sfp_abs, sfp_los, sfp_abs_flag, sfp_los_flag,
                                {lm80_n, sfp_los_int_bit, sfp_abs_int_bit}),
                       rd_data);
            check_bit("reading_abs_int", rd_addr == ADDR_SFP_ONLINE_INT, saw_abs);
            check_bit("reading_los_int", rd_addr == ADDR_SFP_LOS_INT, saw_los);
        end
    end

    initial
    begin
        #((BUS_CYCLES * 12 + 100) * CLK_PERIOD);
        $display("watchdog expired before all tests completed");
        $display("test failed");
        $finish;
    end

    initial
    begin
        int bad;
        rst_n           = 1'b0;
        lbus_addr       = '0;
        lbus_d_in       = '0;
        lbus_cs_n       = 1'b1;
        lbus_rd_n       = 1'b1;
        lbus_wr_n       = 1'b1;
        sfp_abs         = '0;
        sfp_los         = '0;
        sfp_abs_flag    = '1;   // no flag pending
        sfp_los_flag    = '1;
        lm80_n          = 1'b1;
        sfp_abs_int_bit = 1'b0;
        sfp_los_int_bit = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < 8; i++)
            bus_read(lbus_addr_t'(i));
        foreach (RW_ADDRS[i])
            bus_read(RW_ADDRS[i]);
        bus_read(ADDR_INT_SOURCE);
        check_outputs();
        check_bit("int_n", 1'b1, int_n);
        end_test("reset values");

        repeat (6)
        begin
            bus_write(ADDR_CPLD_TEST, lbus_data_t'($random(seed)));
            bus_read(ADDR_CPLD_TEST);
        end
        end_test("scratch inversion");

        foreach (RW_ADDRS[i])
        begin
            repeat (3)
            begin
                bus_write(RW_ADDRS[i], lbus_data_t'($random(seed)));
                check_outputs();
                bus_read(RW_ADDRS[i]);
            end
        end
        end_test("control registers");

        repeat (3)
        begin
            @(posedge clk);
            #1;
            sfp_abs      = sfp_vec_t'($random(seed));
            sfp_los      = sfp_vec_t'($random(seed));
            sfp_abs_flag = sfp_vec_t'($random(seed));
            sfp_los_flag = sfp_vec_t'($random(seed));
            foreach (SFP_RD_ADDRS[i])
                bus_read(SFP_RD_ADDRS[i]);
        end
        end_test("sfp status and flags");

        for (int mb = 0; mb < 2; mb++)
        begin
            bus_write(ADDR_INT_MASK, {5'b0, mb[0], 2'(lbus_data_t'($random(seed)))});
            for (int i = 0; i < 8; i++)
            begin
                drive_irq(i[2], i[1], i[0]);
                bus_read(ADDR_INT_SOURCE);
            end
        end
        end_test("interrupt sources");

        foreach (FREE_ADDRS[i])
        begin
            bus_write(FREE_ADDRS[i], lbus_data_t'($random(seed)));
            check_outputs();
            bus_read(FREE_ADDRS[i]);
        end
        end_test("unmapped addresses");

        bad = errors + lbus_regs_top_i.u_ctrl.u_assert.fails;
        $display("checks %0d, errors %0d, assertion failures %0d, tests ok %0d, tests bad %0d",
                 checks, errors, lbus_regs_top_i.u_ctrl.u_assert.fails, tests_ok, tests_bad);
        if (bad == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* lbus_regs_top.f */
common/lbus_pkg.sv
common/board_pkg.sv
common/reg_access_if.sv
design/lbus_ctrl.sv
design/board_info_regs.sv
design/sfp_regs.sv
design/int_ctrl.sv
design/lbus_regs_top.sv
dv/lbus_regs_assert.sv
dv/lbus_regs_tb.sv

/* Makefile */
TOP = lbus_regs_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f lbus_regs_top.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
